// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_vit_dec
FILELIST  ?= filelist.f
PASS_MSG  := STATUS: PASS

SIM := obj_dir/V$(TOP)

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; status=$$?; echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -q "$(PASS_MSG)"; then \
		exit 0; else exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== acs/acs_unit.sv ====
`timescale 1ns/1ps

module acs_unit import trellis_pkg::*, frame_ctrl_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  phase_t    phase_i,
   input  logic      sym_valid_i,
   input  symbol_t   sym_i,
   output decision_t decision_o
);

   localparam int MW = $bits(metric_t);

   metric_t               pm_q    [NUM_STATES];
   logic [NUM_STATES-1:0] val_q;
   metric_t               pm_cur  [NUM_STATES];
   logic [NUM_STATES-1:0] val_cur;
   metric_t               pm_new  [NUM_STATES];
   logic [NUM_STATES-1:0] val_new;
   logic [NUM_STATES-1:0] msb;
   logic                  norm;
   logic                  acc;

   // Hamming distance to the encoder output of one transition
   function automatic logic [1:0] branch_metric(input logic b, input state_t s,
                                                input symbol_t y);
      logic [3:0] sr;
      symbol_t    diff;
      sr   = {b, s};
      diff = {^(sr & GEN0), ^(sr & GEN1)} ^ y;
      return {1'b0, diff[1]} + {1'b0, diff[0]};
   endfunction

   assign acc = sym_valid_i && ((phase_i == IDLE) || (phase_i == FORWARD));

   // A frame from IDLE starts in state 0 with zero metrics
   assign val_cur = (phase_i == IDLE) ? NUM_STATES'(1) : val_q;

   for (genvar s = 0; s < NUM_STATES; s++) begin : g_acs
      localparam state_t NS = state_t'(s);
      localparam state_t P0 = {NS[STATE_W-2:0], 1'b0};
      localparam state_t P1 = {NS[STATE_W-2:0], 1'b1};

      metric_t sum0;
      metric_t sum1;
      logic    pick1;

      assign pm_cur[s] = (phase_i == IDLE) ? '0 : pm_q[s];
      assign msb[s]    = pm_cur[s][MW-1];

      assign sum0 = pm_cur[P0] + metric_t'(branch_metric(NS[STATE_W-1], P0, sym_i));
      assign sum1 = pm_cur[P1] + metric_t'(branch_metric(NS[STATE_W-1], P1, sym_i));

      // Lower predecessor wins a tie
      assign pick1 = val_cur[P1] && (!val_cur[P0] || (sum1 < sum0));

      assign decision_o[s] = pick1;
      assign val_new[s]    = val_cur[P0] | val_cur[P1];
      assign pm_new[s]     = pick1 ? sum1 : sum0;
   end

   assign norm = &msb;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         for (int i = 0; i < NUM_STATES; i++) begin
            pm_q[i] <= '0;
         end
         val_q <= NUM_STATES'(1);
      end else if (acc) begin
         for (int i = 0; i < NUM_STATES; i++) begin
            pm_q[i] <= norm ? {1'b0, pm_new[i][MW-2:0]} : pm_new[i];
         end
         val_q <= val_new;
      end
   end

endmodule

// ==== common/frame_ctrl_pkg.sv ====
package frame_ctrl_pkg;

   // Frame phases, one frame at a time
   typedef enum logic [1:0] {
      IDLE    = 2'd0,
      FORWARD = 2'd1,
      TRACE   = 2'd2,
      DRAIN   = 2'd3
   } phase_t;

   // Output credits held by the port
   typedef logic [3:0] credit_t;

endpackage

// ==== common/trellis_pkg.sv ====
package trellis_pkg;

   // Rate 1/2 code, constraint length 4
   localparam int NUM_STATES = 8;
   localparam int STATE_W    = 3;
   localparam int TAIL_LEN   = 3;

   // Taps over {new bit, state[2], state[1], state[0]}
   localparam logic [3:0] GEN0 = 4'o15;
   localparam logic [3:0] GEN1 = 4'o17;

   typedef logic [STATE_W-1:0] state_t;

   // Bit s holds the low bit of the winning predecessor of state s
   typedef logic [NUM_STATES-1:0] decision_t;

   typedef logic [7:0] metric_t;

   // Received pair, bit 1 from GEN0 and bit 0 from GEN1
   typedef logic [1:0] symbol_t;

endpackage

// ==== dv/tb_vit_dec.sv ====
`timescale 1ns/1ps

module tb_vit_dec import trellis_pkg::*; ;

   localparam int FRAME_MAX     = 256;
   localparam int OUT_CREDITS   = 4;
   localparam int READY_TIMEOUT = 2000;
   localparam int DONE_TIMEOUT  = 20000;

   logic       clk;
   logic       rst;
   logic       sym_valid;
   logic [1:0] sym;
   logic       sym_last;
   logic       in_ready_o;
   logic       out_valid_o;
   logic       out_bit_o;
   logic       out_credit_i = 1'b0;

   integer seed;
   int     errors;
   int     timeouts;
   bit     alive;
   bit     credit_en;
   int     pending = 0;
   int     rx_count = 0;
   bit     exp_q[$];
   logic   data_bits [FRAME_MAX];
   logic [1:0] sym_buf [FRAME_MAX];

   vit_dec_top #(.FRAME_MAX(FRAME_MAX), .OUT_CREDITS(OUT_CREDITS)) dut0 (
      .clk,
      .rst,
      .sym_valid_i  (sym_valid),
      .sym_i        (sym),
      .sym_last_i   (sym_last),
      .in_ready_o,
      .out_valid_o,
      .out_bit_o,
      .out_credit_i
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Reference encoder, new bit enters the state MSB
   function automatic void encode_frame(input int n_data);
      logic [2:0] st;
      logic [3:0] sr;
      logic       b;
      st = 3'd0;
      for (int i = 0; i < n_data + TAIL_LEN; i++) begin
         b          = (i < n_data) ? data_bits[i] : 1'b0;
         sr         = {b, st};
         sym_buf[i] = {^(sr & GEN0), ^(sr & GEN1)};
         st         = {b, st[2:1]};
      end
   endfunction

   task automatic check_value(input string name, input logic [31:0] expv,
                              input logic [31:0] actv);
      if (expv !== actv) begin
         $display("FAIL %s expected 0x%0h actual 0x%0h", name, expv, actv);
         errors++;
      end
   endtask

   // Cut above zero stops early and leaves no expected bits
   task automatic send_frame(input int n_data, input int period, input int offset,
                             input int cut);
      int n_sym;
      int t;
      if (!alive) return;
      n_sym = n_data + TAIL_LEN;
      for (int i = 0; i < n_data; i++) begin
         data_bits[i] = 1'($random(seed));
      end
      encode_frame(n_data);
      for (int i = 0; i < n_sym; i++) begin
         if (period > 0 && (i % period) == offset) begin
            sym_buf[i][(i / period) % 2] = ~sym_buf[i][(i / period) % 2];
         end
      end
      if (cut == 0) begin
         for (int i = 0; i < n_data; i++) begin
            exp_q.push_back(data_bits[i]);
         end
      end
      for (int i = 0; i < n_sym && (cut == 0 || i < cut) && alive; i++) begin
         @(negedge clk);
         sym_valid = 1'b1;
         sym       = sym_buf[i];
         sym_last  = (cut == 0) && (i == n_sym - 1);
         t = 0;
         while (!in_ready_o && t < READY_TIMEOUT) begin
            @(negedge clk);
            t++;
         end
         if (t >= READY_TIMEOUT) begin
            $display("Timeout: the decoder never became ready for a symbol");
            timeouts++;
            alive = 0;
         end
      end
      @(negedge clk);
      sym_valid = 1'b0;
      sym_last  = 1'b0;
   endtask

   task automatic wait_frame_done();
      int t;
      t = 0;
      if (!alive) return;
      while (!(exp_q.size() == 0 && !out_valid_o && in_ready_o && pending == 0) &&
             t < DONE_TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (t >= DONE_TIMEOUT) begin
         $display("Timeout: the decoded bits of a frame did not all arrive");
         timeouts++;
         alive = 0;
      end
   endtask

   task automatic run_frame(input int n_data, input int period, input int offset);
      int start;
      if (!alive) return;
      start = rx_count;
      send_frame(n_data, period, offset, 0);
      wait_frame_done();
      if (alive) check_value("output bit count", n_data, rx_count - start);
   endtask

   task automatic hold_credits();
      int start;
      if (!alive) return;
      credit_en = 0;
      start = rx_count;
      send_frame(30, 0, 0, 0);
      // Observation window with credit returns withheld
      repeat (200) @(negedge clk);
      check_value("bits delivered without credit returns", OUT_CREDITS, rx_count - start);
      credit_en = 1;
      wait_frame_done();
      if (alive) check_value("output bit count", 30, rx_count - start);
   endtask

   task automatic reset_mid_frame();
      if (!alive) return;
      send_frame(20, 0, 0, 10);
      rst = 1'b0;
      repeat (4) @(negedge clk);
      check_value("out_valid_o", 0, out_valid_o);
      check_value("in_ready_o", 1, in_ready_o);
      rst = 1'b1;
      run_frame(40, 0, 0);
   endtask

   task automatic finish_run();
      $display("Summary: %0d value errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   endtask

   // Receiver returns one credit per delivered bit, at random times
   always @(negedge clk) begin
      if (!rst) begin
         pending      = 0;
         out_credit_i = 1'b0;
      end else begin
         if (out_valid_o) pending++;
         if (credit_en && pending > 0 && ($random(seed) & 3) != 0) begin
            out_credit_i = 1'b1;
            pending--;
         end else begin
            out_credit_i = 1'b0;
         end
      end
   end

   // Compare each delivered bit against the data sent
   always @(negedge clk) begin
      if (rst && out_valid_o) begin
         rx_count++;
         if (exp_q.size() == 0) begin
            $display("Error: an output bit arrived with none expected");
            errors++;
         end else begin
            check_value("out_bit_o", exp_q.pop_front(), out_bit_o);
         end
      end
   end

   initial begin
      int n;
      seed      = 11796;
      alive     = 1;
      errors    = 0;
      timeouts  = 0;
      credit_en = 1;
      rst       = 1'b0;
      sym_valid = 1'b0;
      sym       = 2'b00;
      sym_last  = 1'b0;
      repeat (4) @(negedge clk);
      rst = 1'b1;

      run_frame(40, 0, 0);
      run_frame(60, 13, 5);
      run_frame(60, 13, 9);
      run_frame(FRAME_MAX - TAIL_LEN, 20, 7);
      hold_credits();
      for (int k = 0; k < 6; k++) begin
         n = (k == 0) ? 1 : 1 + ($unsigned($random(seed)) % 60);
         run_frame(n, 0, 0);
      end
      reset_mid_frame();
      finish_run();
   end

endmodule

// ==== dv/vit_dec_props.sv ====
`timescale 1ns/1ps

module vit_dec_props import frame_ctrl_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  phase_t  phase_i,
   input  logic    sym_valid_i,
   input  logic    sym_last_i,
   input  logic    in_ready_i,
   input  logic    out_valid_i,
   input  credit_t cred_i
);

   logic busy_q;

   wire acc      = sym_valid_i && in_ready_i;
   wire out_done = (phase_i == IDLE) && !out_valid_i;

   // Set by the last symbol, cleared once the output side is quiet
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         busy_q <= 1'b0;
      end else if (acc && sym_last_i) begin
         busy_q <= 1'b1;
      end else if (out_done) begin
         busy_q <= 1'b0;
      end
   end

   a_valid_needs_credit: assert property (
      @(posedge clk) disable iff (!rst) out_valid_i |-> (cred_i != '0)
   ) else $error("out_valid_o high with no credit left");

   // Trace-back starts right after the last symbol
   a_ready_low_after_last: assert property (
      @(posedge clk) disable iff (!rst) (acc && sym_last_i) |=> !in_ready_i
   ) else $error("in_ready_o still high after the last symbol of a frame");

   // Ready returns only together with the final delivery of a frame
   a_ready_rises_with_output: assert property (
      @(posedge clk) disable iff (!rst) $rose(in_ready_i) |-> out_valid_i
   ) else $error("in_ready_o rose before the output of the frame was delivered");

   a_no_early_symbol: assert property (
      @(posedge clk) disable iff (!rst) acc |-> (!busy_q || out_done)
   ) else $error("symbol accepted before the previous frame finished output");

endmodule

bind vit_dec_top vit_dec_props props0 (
   .clk,
   .rst,
   .phase_i     (phase),
   .sym_valid_i,
   .sym_last_i,
   .in_ready_i  (in_ready_o),
   .out_valid_i (out_valid_o),
   .cred_i      (port0.cred_q)
);

// ==== filelist.f ====
common/trellis_pkg.sv
common/frame_ctrl_pkg.sv
verilog/frame_ram.sv
verilog/frame_ctrl.sv
verilog/step_counter.sv
acs/acs_unit.sv
traceback/traceback_unit.sv
verilog/out_credit_port.sv
verilog/vit_dec_top.sv
dv/vit_dec_props.sv
dv/tb_vit_dec.sv

// ==== traceback/traceback_unit.sv ====
`timescale 1ns/1ps

module traceback_unit import trellis_pkg::*, frame_ctrl_pkg::*; #(
   parameter int FRAME_MAX = 256
) (
   input  logic                         clk,
   input  logic                         rst,
   input  phase_t                       phase_i,
   input  logic [$clog2(FRAME_MAX)-1:0] step_i,
   input  decision_t                    surv_d_i,
   output logic [$clog2(FRAME_MAX)-1:0] surv_addr_o,
   output logic                         bit_wr_o,
   output logic [$clog2(FRAME_MAX)-1:0] bit_addr_o,
   output logic                         bit_o
);

   localparam int AW = $clog2(FRAME_MAX);

   state_t        st_q;
   logic          rd_vld_q;
   logic [AW-1:0] step_d_q;

   // Survivors are written and read at the current step
   assign surv_addr_o = step_i;

   // First TRACE cycle only issues the read
   assign bit_wr_o   = rd_vld_q && (phase_i == TRACE);
   assign bit_addr_o = step_d_q;
   assign bit_o      = st_q[STATE_W-1];

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         st_q     <= '0;
         rd_vld_q <= 1'b0;
      end else begin
         rd_vld_q <= (phase_i == TRACE);
         if (bit_wr_o) begin
            st_q <= {st_q[STATE_W-2:0], surv_d_i[st_q]};
         end else if (phase_i != TRACE) begin
            st_q <= '0;
         end
      end
   end

   // Step matching the survivor data
   always_ff @(posedge clk) begin
      step_d_q <= step_i;
   end

endmodule

// ==== verilog/frame_ctrl.sv ====
`timescale 1ns/1ps

module frame_ctrl import frame_ctrl_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   sym_valid_i,
   input  logic   sym_last_i,
   input  logic   at_zero_i,
   input  logic   at_drain_end_i,
   input  logic   take_i,
   output phase_t phase_o,
   output logic   in_ready_o,
   output logic   cnt_clear_o,
   output logic   cnt_up_o,
   output logic   cnt_down_o,
   output logic   cnt_capture_o
);

   phase_t phase_q;
   logic   lat_q;
   logic   acc;
   logic   drain_done;

   assign phase_o    = phase_q;
   assign in_ready_o = (phase_q == IDLE) || (phase_q == FORWARD);
   assign acc        = sym_valid_i && in_ready_o;
   assign drain_done = (phase_q == DRAIN) && take_i && at_drain_end_i;

   // Counter commands
   assign cnt_capture_o = acc && sym_last_i;
   assign cnt_up_o      = (acc && !sym_last_i) ||
                          ((phase_q == DRAIN) && take_i && !at_drain_end_i);
   assign cnt_down_o    = (phase_q == TRACE) && !at_zero_i;
   assign cnt_clear_o   = ((phase_q == IDLE) && !acc) || drain_done;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         phase_q <= IDLE;
         lat_q   <= 1'b0;
      end else begin
         case (phase_q)
            IDLE, FORWARD: begin
               if (acc) begin
                  phase_q <= sym_last_i ? TRACE : FORWARD;
               end
            end
            TRACE: begin
               // Step 0 still needs one read cycle
               if (at_zero_i) begin
                  lat_q <= !lat_q;
                  if (lat_q) begin
                     phase_q <= DRAIN;
                  end
               end
            end
            DRAIN: begin
               if (drain_done) begin
                  phase_q <= IDLE;
               end
            end
            default: phase_q <= IDLE;
         endcase
      end
   end

endmodule

// ==== verilog/frame_ram.sv ====
`timescale 1ns/1ps

module frame_ram #(
   parameter int  DEPTH     = 256,
   parameter type payload_t = logic
) (
   input  logic                     clk,
   input  logic                     wr_i,
   input  logic [$clog2(DEPTH)-1:0] addr_i,
   input  payload_t                 d_i,
   output payload_t                 d_o
);

   payload_t mem [DEPTH];

   // Registered read, old data on a write cycle
   always_ff @(posedge clk) begin
      if (wr_i) begin
         mem[addr_i] <= d_i;
      end
      d_o <= mem[addr_i];
   end

endmodule

// ==== verilog/out_credit_port.sv ====
`timescale 1ns/1ps

module out_credit_port import frame_ctrl_pkg::*; #(
   parameter int OUT_CREDITS = 4,
   parameter int FRAME_MAX   = 256
) (
   input  logic                         clk,
   input  logic                         rst,
   input  phase_t                       phase_i,
   input  logic                         bit_i,
   input  logic                         out_credit_i,
   output logic                         out_valid_o,
   output logic                         out_bit_o,
   output logic                         take_o,
   output logic [$clog2(FRAME_MAX)-1:0] rd_addr_o
);

   localparam int AW = $clog2(FRAME_MAX);

   credit_t       cred_q;
   logic          valid_q;
   logic [AW-1:0] rd_q;

   // Keep one credit back for a delivery already in flight
   assign take_o = (phase_i == DRAIN) && (cred_q > credit_t'(valid_q));

   assign out_valid_o = valid_q;
   assign out_bit_o   = bit_i;
   assign rd_addr_o   = rd_q;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         cred_q  <= credit_t'(OUT_CREDITS);
         valid_q <= 1'b0;
         rd_q    <= '0;
      end else begin
         valid_q <= take_o;
         cred_q  <= cred_q - credit_t'(valid_q) + credit_t'(out_credit_i);
         if (phase_i != DRAIN) begin
            rd_q <= '0;
         end else if (take_o) begin
            rd_q <= rd_q + AW'(1);
         end
      end
   end

endmodule

// ==== verilog/step_counter.sv ====
`timescale 1ns/1ps

module step_counter import trellis_pkg::*; #(
   parameter int FRAME_MAX = 256
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clear_i,
   input  logic                         up_i,
   input  logic                         down_i,
   input  logic                         capture_i,
   output logic [$clog2(FRAME_MAX)-1:0] step_o,
   output logic                         at_zero_o,
   output logic                         at_drain_end_o
);

   localparam int AW = $clog2(FRAME_MAX);

   logic [AW-1:0] step_q;
   // Index of the final tail symbol
   logic [AW-1:0] last_q;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         step_q <= '0;
         last_q <= '0;
      end else if (clear_i) begin
         step_q <= '0;
      end else if (capture_i) begin
         last_q <= step_q;
      end else if (down_i) begin
         step_q <= step_q - AW'(1);
      end else if (up_i) begin
         step_q <= step_q + AW'(1);
      end
   end

   assign step_o         = step_q;
   assign at_zero_o      = (step_q == '0);
   assign at_drain_end_o = (step_q == last_q - AW'(TAIL_LEN));

endmodule

// ==== verilog/vit_dec_top.sv ====
`timescale 1ns/1ps

module vit_dec_top import trellis_pkg::*, frame_ctrl_pkg::*; #(
   parameter int FRAME_MAX   = 256,
   parameter int OUT_CREDITS = 4
) (
   input  logic    clk,
   input  logic    rst,
   input  logic    sym_valid_i,
   input  symbol_t sym_i,
   input  logic    sym_last_i,
   output logic    in_ready_o,
   output logic    out_valid_o,
   output logic    out_bit_o,
   input  logic    out_credit_i
);

   localparam int AW = $clog2(FRAME_MAX);

   phase_t          phase;
   logic            cnt_clear;
   logic            cnt_up;
   logic            cnt_down;
   logic            cnt_capture;
   logic [AW-1:0]   step;
   logic            at_zero;
   logic            at_drain_end;
   logic            take;
   decision_t       decision;
   decision_t       surv_d;
   logic [AW-1:0]   surv_addr;
   logic            bit_wr;
   logic [AW-1:0]   bit_addr;
   logic            tb_bit;
   logic [AW-1:0]   rd_addr;
   logic            out_ram_d;

   // Symbol accepted on this edge
   wire sym_acc = sym_valid_i & in_ready_o;

   // Output memory is written in TRACE and read in DRAIN
   wire [AW-1:0] out_addr = bit_wr ? bit_addr : rd_addr;

   frame_ctrl ctrl0 (
      .clk,
      .rst,
      .sym_valid_i,
      .sym_last_i,
      .at_zero_i      (at_zero),
      .at_drain_end_i (at_drain_end),
      .take_i         (take),
      .phase_o        (phase),
      .in_ready_o,
      .cnt_clear_o    (cnt_clear),
      .cnt_up_o       (cnt_up),
      .cnt_down_o     (cnt_down),
      .cnt_capture_o  (cnt_capture)
   );

   step_counter #(.FRAME_MAX(FRAME_MAX)) cnt0 (
      .clk,
      .rst,
      .clear_i        (cnt_clear),
      .up_i           (cnt_up),
      .down_i         (cnt_down),
      .capture_i      (cnt_capture),
      .step_o         (step),
      .at_zero_o      (at_zero),
      .at_drain_end_o (at_drain_end)
   );

   acs_unit acs0 (
      .clk,
      .rst,
      .phase_i    (phase),
      .sym_valid_i,
      .sym_i,
      .decision_o (decision)
   );

   frame_ram #(.DEPTH(FRAME_MAX), .payload_t(decision_t)) surv_ram0 (
      .clk,
      .wr_i   (sym_acc),
      .addr_i (surv_addr),
      .d_i    (decision),
      .d_o    (surv_d)
   );

   traceback_unit #(.FRAME_MAX(FRAME_MAX)) tb0 (
      .clk,
      .rst,
      .phase_i     (phase),
      .step_i      (step),
      .surv_d_i    (surv_d),
      .surv_addr_o (surv_addr),
      .bit_wr_o    (bit_wr),
      .bit_addr_o  (bit_addr),
      .bit_o       (tb_bit)
   );

   frame_ram #(.DEPTH(FRAME_MAX), .payload_t(logic)) out_ram0 (
      .clk,
      .wr_i   (bit_wr),
      .addr_i (out_addr),
      .d_i    (tb_bit),
      .d_o    (out_ram_d)
   );

   out_credit_port #(.OUT_CREDITS(OUT_CREDITS), .FRAME_MAX(FRAME_MAX)) port0 (
      .clk,
      .rst,
      .phase_i   (phase),
      .bit_i     (out_ram_d),
      .out_credit_i,
      .out_valid_o,
      .out_bit_o,
      .take_o    (take),
      .rd_addr_o (rd_addr)
   );

endmodule
